// ==== Bender.yml ====
package:
  name: miss_subsystem

sources:
  # Design sources in compile order
  - files:
      - rtl/mhq_pkg.sv
      - rtl/biu_if.sv
      - rtl/mhq.sv
      - rtl/biu.sv
      - rtl/miss_subsystem.sv

  # Simulation only
  - target: test
    files:
      - verification/tb_mem_model.sv
      - verification/tb_miss_subsystem.sv

// ==== filelist.f ====
rtl/mhq_pkg.sv
rtl/biu_if.sv
rtl/mhq.sv
rtl/biu.sv
rtl/miss_subsystem.sv
verification/tb_mem_model.sv
verification/tb_miss_subsystem.sv

// ==== rtl/biu.sv ====
// Bus interface unit that fetches one cache line as a series of single word reads
`timescale 1ns/100ps
`default_nettype none

module biu
    import mhq_pkg::*;
(
    input  logic    clk,
    input  logic    n_rst,

    // Word-wide memory read bus
    output logic    o_mem_rd_en,
    output addr_t   o_mem_addr,
    input  logic    i_mem_rd_valid,
    input  word_t   i_mem_rd_data,

    biu_if.biu_port bus
);

    logic [1:0]                    state;
    logic [$clog2(LINE_WORDS)-1:0] word_idx;
    logic                          done_q;
    logic                          start;
    logic                          last_word;
    line_addr_t                    line_addr;
    line_t                         line_buf;

    // The request is still high during the done cycle, so wait for it to drop
    // or move on to the next head before starting again
    assign start     = (state == BIU_IDLE) && bus.req_en && !done_q;
    assign last_word = (int'(word_idx) == LINE_WORDS - 1);

    assign o_mem_rd_en = (state == BIU_ISSUE);
    assign o_mem_addr  = {line_addr, word_idx, {$clog2(WORD_BYTES){1'b0}}};

    assign bus.done = done_q;
    assign bus.data = line_buf;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state    <= BIU_IDLE;
            word_idx <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                BIU_IDLE: begin
                    if (start) begin
                        word_idx <= '0;
                        state    <= BIU_ISSUE;
                    end
                end
                BIU_ISSUE: begin
                    state <= BIU_WAIT;
                end
                BIU_WAIT: begin
                    if (i_mem_rd_valid) begin
                        if (last_word) begin
                            done_q <= 1'b1;
                            state  <= BIU_IDLE;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            state    <= BIU_ISSUE;
                        end
                    end
                end
                default: begin
                    state <= BIU_IDLE;
                end
            endcase
        end
    end

    // Line address and the assembled words
    always_ff @(posedge clk) begin
        if (start) begin
            line_addr <= bus.req_addr;
        end
        if ((state == BIU_WAIT) && i_mem_rd_valid) begin
            line_buf.words[word_idx] <= i_mem_rd_data;
        end
    end

    // Memory must not answer unless a read is outstanding
    a_valid_needs_read: assert property (
        @(posedge clk) disable iff (!n_rst) i_mem_rd_valid |-> (state == BIU_WAIT)
    ) else $error("Read data returned with no read outstanding");

    // After a read is issued no other read goes out until its data is back
    a_one_read_out: assert property (
        @(posedge clk) disable iff (!n_rst)
        o_mem_rd_en |=> (!o_mem_rd_en until_with i_mem_rd_valid)
    ) else $error("Second read issued while one is outstanding");

endmodule

`default_nettype wire

// ==== rtl/biu_if.sv ====
// Line fetch channel between the miss handling queue and the bus interface unit
`timescale 1ns/100ps
`default_nettype none

interface biu_if
    import mhq_pkg::*;
();

    // Request side held by the MHQ while the head entry is pending
    logic       req_en;
    line_addr_t req_addr;

    // Response side whose data is valid only in the done cycle
    logic       done;
    line_t      data;

    modport mhq_port (
        output req_en,
        output req_addr,
        input  done,
        input  data
    );

    modport biu_port (
        input  req_en,
        input  req_addr,
        output done,
        output data
    );

endinterface

`default_nettype wire

// ==== rtl/mhq.sv ====
// Miss handling queue that merges misses per line, keeps store bytes and broadcasts fills
`timescale 1ns/100ps
`default_nettype none

module mhq
    import mhq_pkg::*;
(
    input  logic           clk,
    input  logic           n_rst,

    // Miss enqueue from the LSU
    input  logic           i_enq_en,
    input  logic           i_enq_we,
    input  addr_t          i_enq_addr,
    input  byte_sel_t      i_enq_byte_select,
    input  word_t          i_enq_data,
    output mhq_tag_t       o_enq_tag,
    output logic           o_full,

    // Fill broadcast
    output logic           o_fill,
    output mhq_tag_t       o_fill_tag,
    output logic           o_fill_dirty,
    output addr_t          o_fill_addr,
    output line_t          o_fill_data,

    biu_if.mhq_port        biu
);

    // Head and tail carry one extra wrap bit to tell full from empty
    logic [TAG_WIDTH:0]    head_p;
    logic [TAG_WIDTH:0]    tail_p;
    mhq_tag_t              head;
    mhq_tag_t              tail;
    logic                  full;

    // Entry fields
    logic                  entry_valid   [MHQ_DEPTH];
    logic                  entry_dirty   [MHQ_DEPTH];
    logic [LINE_BYTES-1:0] entry_updated [MHQ_DEPTH];
    line_addr_t            entry_line    [MHQ_DEPTH];
    line_t                 entry_data    [MHQ_DEPTH];

    // Enqueue decode
    line_addr_t            enq_line;
    logic [OFFSET_WIDTH-1:0] enq_offset;
    logic [LINE_BYTES-1:0] enq_byte_en;
    line_t                 enq_line_data;
    logic [MHQ_DEPTH-1:0]  enq_match;
    mhq_tag_t              match_tag;
    mhq_tag_t              enq_tag;
    logic                  enq_alloc;
    logic                  enq_we;
    logic [LINE_BYTES-1:0] enq_mask_next;

    assign head = head_p[TAG_WIDTH-1:0];
    assign tail = tail_p[TAG_WIDTH-1:0];
    assign full = (head_p[TAG_WIDTH] != tail_p[TAG_WIDTH]) && (head == tail);

    assign enq_line   = i_enq_addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    assign enq_offset = i_enq_addr[OFFSET_WIDTH-1:0];

    // Move the store word and its byte enables to their place in the line
    assign enq_byte_en   = {{(LINE_BYTES-WORD_BYTES){1'b0}}, i_enq_byte_select} << enq_offset;
    assign enq_line_data = {{(LINE_BYTES*8-WORD_WIDTH){1'b0}}, i_enq_data} << {enq_offset, 3'b000};

    // The head entry drops out of the compare while its fill completes, so a
    // late store to that line opens a fresh entry instead of being lost
    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            enq_match[i] = entry_valid[i] && (entry_line[i] == enq_line) &&
                           !(biu.done && (head == mhq_tag_t'(i)));
        end
    end

    always_comb begin
        match_tag = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (enq_match[i]) begin
                match_tag = mhq_tag_t'(i);
            end
        end
    end

    assign enq_alloc = i_enq_en && !(|enq_match);
    assign enq_we    = i_enq_en && i_enq_we;
    assign enq_tag   = enq_alloc ? tail : match_tag;

    // A freshly allocated entry starts with an empty byte mask
    assign enq_mask_next = (enq_alloc ? '0 : entry_updated[enq_tag]) | enq_byte_en;

    assign o_enq_tag = enq_tag;
    assign o_full    = full;

    // Request the line at the head of the queue
    assign biu.req_en   = entry_valid[head];
    assign biu.req_addr = entry_line[head];

    // Fill broadcast where store bytes win over the bytes from memory
    assign o_fill       = biu.done;
    assign o_fill_tag   = head;
    assign o_fill_dirty = entry_dirty[head];
    assign o_fill_addr  = {entry_line[head], {OFFSET_WIDTH{1'b0}}};

    always_comb begin
        for (int j = 0; j < LINE_BYTES; j++) begin
            o_fill_data.bytes[j] = entry_updated[head][j] ? entry_data[head].bytes[j]
                                                          : biu.data.bytes[j];
        end
    end

    // Entry control state
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < MHQ_DEPTH; i++) begin
                entry_valid[i]   <= 1'b0;
                entry_dirty[i]   <= 1'b0;
                entry_updated[i] <= '0;
            end
        end else begin
            for (int i = 0; i < MHQ_DEPTH; i++) begin
                if (biu.done && (head == mhq_tag_t'(i))) begin
                    entry_valid[i] <= 1'b0;
                end
                if (enq_alloc && (tail == mhq_tag_t'(i))) begin
                    entry_valid[i]   <= 1'b1;
                    entry_dirty[i]   <= 1'b0;
                    entry_updated[i] <= '0;
                end
                // Later assignment wins, so a store on allocation still marks the entry
                if (enq_we && (enq_tag == mhq_tag_t'(i))) begin
                    entry_dirty[i]   <= 1'b1;
                    entry_updated[i] <= enq_mask_next;
                end
            end
        end
    end

    // Line number is captured when the entry is allocated
    always_ff @(posedge clk) begin
        if (enq_alloc) begin
            entry_line[tail] <= enq_line;
        end
    end

    // Store bytes are written only where the byte enables are set
    always_ff @(posedge clk) begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            for (int j = 0; j < LINE_BYTES; j++) begin
                if (enq_we && (enq_tag == mhq_tag_t'(i)) && enq_byte_en[j]) begin
                    entry_data[i].bytes[j] <= enq_line_data.bytes[j];
                end
            end
        end
    end

    // Tail moves on allocation and head moves when the fill completes
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            tail_p <= '0;
            head_p <= '0;
        end else begin
            if (enq_alloc) begin
                tail_p <= tail_p + 1'b1;
            end
            if (biu.done) begin
                head_p <= head_p + 1'b1;
            end
        end
    end

    // The LSU must hold back new misses while the queue is full
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (!n_rst) enq_alloc |-> !full
    ) else $error("Miss allocated while the queue is full");

    // The BIU only completes a fetch that the head entry asked for
    a_done_needs_head: assert property (
        @(posedge clk) disable iff (!n_rst) biu.done |-> entry_valid[head]
    ) else $error("Fill completed with no valid head entry");

endmodule

`default_nettype wire

// ==== rtl/mhq_pkg.sv ====
// Miss path package with address, line and queue sizes, their types and the cache line layout
`default_nettype none

package mhq_pkg;

    // Address and data sizes
    localparam int ADDR_WIDTH   = 32;
    localparam int WORD_WIDTH   = 32;
    localparam int WORD_BYTES   = 4;

    // Cache line geometry
    localparam int LINE_BYTES   = 16;
    localparam int LINE_WORDS   = 4;
    localparam int OFFSET_WIDTH = 4;

    // Miss queue geometry
    localparam int MHQ_DEPTH    = 4;
    localparam int TAG_WIDTH    = 2;

    // BIU state encodings
    localparam logic [1:0] BIU_IDLE  = 2'd0;
    localparam logic [1:0] BIU_ISSUE = 2'd1;
    localparam logic [1:0] BIU_WAIT  = 2'd2;

    typedef logic [ADDR_WIDTH-1:0]              addr_t;
    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] line_addr_t;
    typedef logic [WORD_WIDTH-1:0]              word_t;
    typedef logic [WORD_BYTES-1:0]              byte_sel_t;
    typedef logic [TAG_WIDTH-1:0]               mhq_tag_t;

    // The MHQ merges store bytes into the line byte by byte, while the BIU
    // assembles the same line one bus word at a time
    typedef union packed {
        logic [LINE_BYTES-1:0][7:0]            bytes;
        logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] words;
    } line_t;

endpackage

`default_nettype wire

// ==== rtl/miss_subsystem.sv ====
// Miss path top level joining the miss handling queue and the bus interface unit
`timescale 1ns/100ps
`default_nettype none

module miss_subsystem
    import mhq_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,

    // LSU miss enqueue
    input  logic      i_enq_en,
    input  logic      i_enq_we,
    input  addr_t     i_enq_addr,
    input  byte_sel_t i_enq_byte_select,
    input  word_t     i_enq_data,
    output mhq_tag_t  o_enq_tag,
    output logic      o_full,

    // Fill broadcast
    output logic      o_fill,
    output mhq_tag_t  o_fill_tag,
    output logic      o_fill_dirty,
    output addr_t     o_fill_addr,
    output line_t     o_fill_data,

    // Memory read bus
    output logic      o_mem_rd_en,
    output addr_t     o_mem_addr,
    input  logic      i_mem_rd_valid,
    input  word_t     i_mem_rd_data
);

    biu_if biu_bus ();

    mhq mhq_inst (
        .clk               (clk),
        .n_rst             (n_rst),
        .i_enq_en          (i_enq_en),
        .i_enq_we          (i_enq_we),
        .i_enq_addr        (i_enq_addr),
        .i_enq_byte_select (i_enq_byte_select),
        .i_enq_data        (i_enq_data),
        .o_enq_tag         (o_enq_tag),
        .o_full            (o_full),
        .o_fill            (o_fill),
        .o_fill_tag        (o_fill_tag),
        .o_fill_dirty      (o_fill_dirty),
        .o_fill_addr       (o_fill_addr),
        .o_fill_data       (o_fill_data),
        .biu               (biu_bus.mhq_port)
    );

    biu biu_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .o_mem_rd_en    (o_mem_rd_en),
        .o_mem_addr     (o_mem_addr),
        .i_mem_rd_valid (i_mem_rd_valid),
        .i_mem_rd_data  (i_mem_rd_data),
        .bus            (biu_bus.biu_port)
    );

endmodule

`default_nettype wire

// ==== verification/tb_mem_model.sv ====
// Memory responder that answers each word read after a random delay with address-derived data
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model
    import mhq_pkg::*;
#(
    parameter word_t DATA_PATTERN = 32'h0
)(
    input  logic  clk,
    input  logic  n_rst,
    input  logic  i_rd_en,
    input  addr_t i_addr,
    output logic  o_rd_valid,
    output word_t o_rd_data
);

    localparam int SEED        = 50;
    localparam int MIN_LATENCY = 1;
    localparam int MAX_LATENCY = 4;

    logic        pending;
    int unsigned delay;
    addr_t       addr_q;

    // One read at a time is answered on a falling edge so the BIU samples stable data
    initial begin
        void'($urandom(SEED));
        pending    = 1'b0;
        delay      = 0;
        addr_q     = '0;
        o_rd_valid = 1'b0;
        o_rd_data  = '0;
        forever begin
            @(negedge clk);
            o_rd_valid <= 1'b0;
            if (!n_rst) begin
                pending = 1'b0;
            end else if (pending) begin
                if (delay == 0) begin
                    o_rd_valid <= 1'b1;
                    o_rd_data  <= word_t'(addr_q >> 2) ^ DATA_PATTERN;
                    pending = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end else if (i_rd_en) begin
                pending = 1'b1;
                addr_q  = i_addr;
                delay   = $urandom_range(MAX_LATENCY - 1, MIN_LATENCY - 1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_miss_subsystem.sv ====
// Testbench for the cache miss subsystem with directed enqueue and fill tests
`timescale 1ns/100ps
`default_nettype none

module tb_miss_subsystem
    import mhq_pkg::*;
();

    localparam int    CLK_PERIOD      = 20;
    localparam int    RESET_CYCLES    = 10;
    localparam int    LINE_BITS       = LINE_BYTES * 8;
    localparam word_t DATA_PATTERN    = 32'h5A3C_96E1;
    localparam int    SETTLE_CYCLES   = 40;
    // Each word takes one issue cycle and at most four cycles of latency
    localparam int    FILL_CYCLES_MAX = LINE_WORDS * (1 + 4) + 4;
    localparam int    NUM_FILLS       = 8;
    localparam int    TIMEOUT_CYCLES  = 2 * (2 * RESET_CYCLES + NUM_FILLS * FILL_CYCLES_MAX +
                                             6 * SETTLE_CYCLES + 100);

    logic           clk;
    logic           n_rst;
    logic           enq_en;
    logic           enq_we;
    addr_t          enq_addr;
    byte_sel_t      enq_byte_select;
    word_t          enq_data;
    mhq_tag_t       enq_tag;
    logic           full;
    logic           fill;
    mhq_tag_t       fill_tag;
    logic           fill_dirty;
    addr_t          fill_addr;
    line_t          fill_data;
    logic           mem_rd_en;
    addr_t          mem_addr;
    logic           mem_rd_valid;
    word_t          mem_rd_data;

    int unsigned    cycle_count = 0;
    mhq_tag_t       fill_tag_q   [$];
    addr_t          fill_addr_q  [$];
    logic           fill_dirty_q [$];
    logic [LINE_BITS-1:0] fill_data_q [$];

    miss_subsystem miss_subsystem_inst (
        .clk               (clk),
        .n_rst             (n_rst),
        .i_enq_en          (enq_en),
        .i_enq_we          (enq_we),
        .i_enq_addr        (enq_addr),
        .i_enq_byte_select (enq_byte_select),
        .i_enq_data        (enq_data),
        .o_enq_tag         (enq_tag),
        .o_full            (full),
        .o_fill            (fill),
        .o_fill_tag        (fill_tag),
        .o_fill_dirty      (fill_dirty),
        .o_fill_addr       (fill_addr),
        .o_fill_data       (fill_data),
        .o_mem_rd_en       (mem_rd_en),
        .o_mem_addr        (mem_addr),
        .i_mem_rd_valid    (mem_rd_valid),
        .i_mem_rd_data     (mem_rd_data)
    );

    tb_mem_model #(
        .DATA_PATTERN (DATA_PATTERN)
    ) mem_model_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_rd_en    (mem_rd_en),
        .i_addr     (mem_addr),
        .o_rd_valid (mem_rd_valid),
        .o_rd_data  (mem_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("TEST FAIL");
            $fatal(1, "Timeout: the tests did not finish within %0d clock cycles",
                   TIMEOUT_CYCLES);
        end
    end

    // Fill monitor that records one entry per fill cycle
    always @(posedge clk) begin
        if (n_rst && fill) begin
            fill_tag_q.push_back(fill_tag);
            fill_addr_q.push_back(fill_addr);
            fill_dirty_q.push_back(fill_dirty);
            fill_data_q.push_back(fill_data);
        end
    end

    // Word w of a line holds its word address XOR the memory pattern
    function automatic logic [LINE_BITS-1:0] mem_line(input addr_t line_base);
        logic [LINE_BITS-1:0] line;
        addr_t                word_addr;
        for (int w = 0; w < LINE_WORDS; w++) begin
            word_addr = (line_base + addr_t'(w * WORD_BYTES)) >> 2;
            line[w*WORD_WIDTH +: WORD_WIDTH] = word_addr ^ DATA_PATTERN;
        end
        return line;
    endfunction

    function automatic logic [LINE_BITS-1:0] store_bytes(input logic [LINE_BITS-1:0] line,
                                                         input addr_t addr, input byte_sel_t sel,
                                                         input word_t data);
        logic [LINE_BITS-1:0] merged;
        int                   offset;
        merged = line;
        offset = int'(addr[OFFSET_WIDTH-1:0]);
        for (int k = 0; k < WORD_BYTES; k++) begin
            if (sel[k]) begin
                merged[(offset+k)*8 +: 8] = data[k*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_value(input logic [LINE_BITS-1:0] actual,
                               input logic [LINE_BITS-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        n_rst = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        n_rst = 1'b1;
        fill_tag_q.delete();
        fill_addr_q.delete();
        fill_dirty_q.delete();
        fill_data_q.delete();
    endtask

    // The tag is sampled just before the edge that takes the enqueue
    task automatic enqueue(input addr_t addr, input logic we, input byte_sel_t sel,
                           input word_t data, output mhq_tag_t tag);
        @(negedge clk);
        enq_en          = 1'b1;
        enq_we          = we;
        enq_addr        = addr;
        enq_byte_select = sel;
        enq_data        = data;
        @(posedge clk);
        tag = enq_tag;
        @(negedge clk);
        enq_en = 1'b0;
        enq_we = 1'b0;
    endtask

    task automatic wait_fills(input int count);
        while (fill_tag_q.size() < count) @(posedge clk);
    endtask

    task automatic settle_and_count(input int count);
        repeat (SETTLE_CYCLES) @(posedge clk);
        check_value(fill_tag_q.size(), count, "number of fills");
    endtask

    task automatic check_fill(input int idx, input mhq_tag_t tag, input addr_t addr,
                              input logic dirty, input logic [LINE_BITS-1:0] data);
        check_value(fill_tag_q[idx], tag, "fill tag");
        check_value(fill_addr_q[idx], addr, "fill address");
        check_value(fill_dirty_q[idx], dirty, "fill dirty flag");
        check_value(fill_data_q[idx], data, "fill data");
    endtask

    task automatic test_reset_state();
        check_value(fill, 1'b0, "o_fill after reset");
        check_value(mem_rd_en, 1'b0, "o_mem_rd_en after reset");
        check_value(full, 1'b0, "o_full after reset");
    endtask

    task automatic test_load_miss();
        mhq_tag_t tag;
        enqueue(32'h0001_0008, 1'b0, 4'h0, '0, tag);
        check_value(tag, 0, "load miss tag");
        wait_fills(1);
        check_fill(0, 2'd0, 32'h0001_0000, 1'b0, mem_line(32'h0001_0000));
        settle_and_count(1);
    endtask

    task automatic test_store_merge();
        mhq_tag_t             tag_a;
        mhq_tag_t             tag_b;
        logic [LINE_BITS-1:0] expected;
        expected = mem_line(32'h0002_0040);
        expected = store_bytes(expected, 32'h0002_0044, 4'b0011, 32'h1122_3344);
        expected = store_bytes(expected, 32'h0002_004C, 4'b1000, 32'hAB00_0000);
        enqueue(32'h0002_0044, 1'b1, 4'b0011, 32'h1122_3344, tag_a);
        enqueue(32'h0002_004C, 1'b1, 4'b1000, 32'hAB00_0000, tag_b);
        check_value(tag_a, 1, "store miss tag");
        check_value(tag_b, tag_a, "tag of second store to the pending line");
        wait_fills(2);
        check_fill(1, 2'd1, 32'h0002_0040, 1'b1, expected);
        settle_and_count(2);
    endtask

    task automatic test_same_line_merge();
        mhq_tag_t tag_a;
        mhq_tag_t tag_b;
        enqueue(32'h0003_0080, 1'b0, 4'h0, '0, tag_a);
        enqueue(32'h0003_008C, 1'b0, 4'h0, '0, tag_b);
        check_value(tag_a, 2, "load miss tag");
        check_value(tag_b, tag_a, "tag of second miss to the pending line");
        wait_fills(3);
        check_fill(2, 2'd2, 32'h0003_0080, 1'b0, mem_line(32'h0003_0080));
        settle_and_count(3);
    endtask

    task automatic test_fill_queue();
        mhq_tag_t tag;
        apply_reset();
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            enqueue(32'h1000_0000 + addr_t'(i * 'h100), 1'b0, 4'h0, '0, tag);
            check_value(tag, i, "tag of queued miss");
            check_value(full, i == MHQ_DEPTH - 1, "o_full while the queue fills");
        end
        wait_fills(MHQ_DEPTH);
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            check_fill(i, mhq_tag_t'(i), 32'h1000_0000 + addr_t'(i * 'h100), 1'b0,
                       mem_line(32'h1000_0000 + addr_t'(i * 'h100)));
        end
        settle_and_count(MHQ_DEPTH);
        check_value(full, 1'b0, "o_full after the queue drains");
        enqueue(32'h2000_0010, 1'b0, 4'h0, '0, tag);
        check_value(tag, 0, "tag after wrap");
        wait_fills(MHQ_DEPTH + 1);
        check_fill(MHQ_DEPTH, 2'd0, 32'h2000_0010, 1'b0, mem_line(32'h2000_0010));
        settle_and_count(MHQ_DEPTH + 1);
    endtask

    initial begin
        n_rst           = 1'b0;
        enq_en          = 1'b0;
        enq_we          = 1'b0;
        enq_addr        = '0;
        enq_byte_select = '0;
        enq_data        = '0;
        apply_reset();
        test_reset_state();
        test_load_miss();
        test_store_merge();
        test_same_line_merge();
        test_fill_queue();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
